//--- bench/mpmem_tb.sv
`include "mpmem_cfg.svh"

module mpmem_tb import mpmem_addr_pkg::*; ();

  localparam int NUM_REQ        = 400;
  localparam int NUM_ADDR       = `MP_NUM_BANKS * `MP_NUM_ROWS;
  localparam int ADDR_W         = `MP_BANK_BITS + `MP_ROW_BITS;
  localparam int CONFLICT_START = 100;
  localparam int SAME_START     = 200;
  localparam int BURST_START    = 250;
  localparam int SWEEP_START    = NUM_REQ - NUM_ADDR;
  localparam int MAX_CYCLES     = 5 + `MP_NUM_ROWS + 2 + 4 * NUM_REQ;

  logic       clk;
  logic       rstvld;
  logic [1:0] wr_en;
  addr_t      wr_addr0;
  addr_t      wr_addr1;
  data_t      wr_data0;
  data_t      wr_data1;
  logic       rd_en;
  addr_t      rd_addr;
  logic       rd_vld;
  data_t      rd_data;
  logic       ready;

  // Reference memory with a written flag per address
  data_t model_mem [NUM_ADDR];
  logic  model_written [NUM_ADDR];

  int    seed = 32'h250d_7d0a;
  int    n_checks = 0;
  int    n_errors = 0;
  int    cycle_cnt = 0;
  int    req_cycles = 0;
  logic  pend_rd = 1'b0;
  logic  pend_known = 1'b0;
  data_t pend_exp;
  addr_t pend_addr;
  string pend_test = "reset";
  bank_t focus_bank;
  row_t  burst_row;
  addr_t same_addr;
  logic  burst_stall = 1'b0;

  mpmem_top i_dut (
    .clk(clk), .rstvld(rstvld), .wr_en(wr_en), .wr_addr0(wr_addr0), .wr_addr1(wr_addr1),
    .wr_data0(wr_data0), .wr_data1(wr_data1), .rd_en(rd_en), .rd_addr(rd_addr),
    .rd_vld(rd_vld), .rd_data(rd_data), .ready(ready)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the request sequence never completed", cycle_cnt);
      $display("Regression failed");
      $finish;
    end
  end

  task automatic idle_inputs();
    wr_en = 2'b00;
    rd_en = 1'b0;
  endtask

  // Result of the read issued one edge earlier, or no rd_vld at all
  task automatic check_read_result();
    n_checks++;
    assert (rd_vld === pend_rd) else begin
      n_errors++;
      $display("CHECK FAILED %s rd_vld expected %0b actual %0b", pend_test, pend_rd, rd_vld);
    end
    if (pend_rd && pend_known) begin
      n_checks++;
      assert (rd_data === pend_exp) else begin
        n_errors++;
        $display("CHECK FAILED %s rd_data addr %h expected %h actual %h",
                 pend_test, pend_addr, pend_exp, rd_data);
      end
    end
    pend_rd = 1'b0;
  endtask

  task automatic make_request(input int idx);
    logic [31:0] rnd;
    logic [31:0] c;
    logic [1:0]  we;
    logic        re;
    addr_t       a0;
    addr_t       a1;
    addr_t       ra;
    data_t       d0;
    data_t       d1;
    rnd = $random(seed);
    a0  = rnd[ADDR_W-1:0];
    a1  = rnd[2*ADDR_W-1:ADDR_W];
    ra  = rnd[3*ADDR_W-1:2*ADDR_W];
    rnd = $random(seed);
    d0  = rnd[`MP_DATA_WIDTH-1:0];
    d1  = rnd[2*`MP_DATA_WIDTH-1:`MP_DATA_WIDTH];
    c   = $random(seed);
    if (idx < CONFLICT_START) begin
      pend_test = "single_rw";
      we = c[0] ? (c[1] ? 2'b10 : 2'b01) : 2'b00;
      re = c[2];
    end else if (idx < SAME_START) begin
      // Writes and reads pile onto one bank to force cache use and eviction
      pend_test = "bank_conflict";
      if (idx == CONFLICT_START) begin
        focus_bank = c[`MP_BANK_BITS+7:8];
      end
      a0.bank = focus_bank;
      if (c[3]) begin
        a1.bank = focus_bank;
      end
      if (a1.row == a0.row) begin
        a1.row = a0.row + 1'b1;
      end
      if (c[4]) begin
        ra.bank = focus_bank;
      end
      we = 2'b11;
      re = c[6:5] != 2'b00;
    end else if (idx < BURST_START) begin
      // Even cycles write one address on both ports and read it back, odd cycles reread
      pend_test = "same_addr";
      we = 2'b00;
      if (idx % 2 == 0) begin
        same_addr = a0;
        a1 = a0;
        we = 2'b11;
      end
      ra = same_addr;
      re = 1'b1;
    end else if (idx < SWEEP_START) begin
      // One row for several cycles keeps the queue draining one entry at a time
      pend_test = "burst";
      if ((idx - BURST_START) % 8 == 0) begin
        burst_row = c[`MP_ROW_BITS+9:10];
      end
      a0.row = burst_row;
      a1.row = burst_row;
      we = 2'b11;
      re = 1'b0;
    end else begin
      pend_test = "final_sweep";
      rnd = idx - SWEEP_START;
      ra = rnd[ADDR_W-1:0];
      we = 2'b00;
      re = 1'b1;
    end
    // Read sees the state before this cycle's writes
    pend_rd    = re;
    pend_addr  = ra;
    pend_known = model_written[ra];
    pend_exp   = model_mem[ra];
    if (we[0]) begin
      model_mem[a0]     = d0;
      model_written[a0] = 1'b1;
    end
    if (we[1]) begin
      model_mem[a1]     = d1;
      model_written[a1] = 1'b1;
    end
    wr_en    = we;
    wr_addr0 = a0;
    wr_addr1 = a1;
    wr_data0 = d0;
    wr_data1 = d1;
    rd_en    = re;
    rd_addr  = ra;
  endtask

  initial begin
    for (int i = 0; i < NUM_ADDR; i++) begin
      model_written[i] = 1'b0;
    end
    rstvld   = 1'b1;
    wr_en    = 2'b00;
    wr_addr0 = '0;
    wr_addr1 = '0;
    wr_data0 = '0;
    wr_data1 = '0;
    rd_en    = 1'b0;
    rd_addr  = '0;
    repeat (5) @(posedge clk);
    #2 rstvld = 1'b0;

    // Ready stays low through the init sweep
    for (int n = 1; n <= `MP_NUM_ROWS + 1; n++) begin
      @(posedge clk);
      #2;
      n_checks++;
      assert (ready === (n == `MP_NUM_ROWS + 1)) else begin
        n_errors++;
        $display("CHECK FAILED init ready at edge %0d expected %0b actual %0b",
                 n, n == `MP_NUM_ROWS + 1, ready);
      end
      n_checks++;
      assert (rd_vld === 1'b0) else begin
        n_errors++;
        $display("CHECK FAILED init rd_vld at edge %0d expected 0 actual %0b", n, rd_vld);
      end
    end

    while (req_cycles < NUM_REQ) begin
      check_read_result();
      if (ready) begin
        make_request(req_cycles);
        req_cycles++;
      end else begin
        idle_inputs();
        if (req_cycles >= BURST_START && req_cycles < SWEEP_START) begin
          burst_stall = 1'b1;
        end
      end
      @(posedge clk);
      #2;
    end
    check_read_result();
    idle_inputs();

    assert (burst_stall) else begin
      n_errors++;
      $display("Ready never fell during the dual write bursts");
    end

    $display("Checks run %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
hw/mpmem_addr_pkg.sv
hw/mpmem_route_pkg.sv
hw/write_queue.sv
hw/drain_ctrl.sv
hw/row_store.sv
hw/pivot_banks.sv
hw/read_path.sv
hw/mpmem_top.sv
bench/mpmem_tb.sv

//--- hw/drain_ctrl.sv
module drain_ctrl import mpmem_addr_pkg::*, mpmem_route_pkg::*; (
  input  qcount_t    count,
  input  logic       rd_en,
  input  addr_t      rd_addr,
  input  logic       head0_vld,
  input  addr_t      head0_addr,
  input  data_t      head0_data,
  input  logic       head1_vld,
  input  addr_t      head1_addr,
  input  data_t      head1_data,
  input  map_entry_t map0,
  input  map_entry_t map1,
  input  data_t      cache1_data,
  output logic [1:0] deq_cnt,
  output logic       pa_wr,
  output bank_t      pa_bank,
  output row_t       pa_row,
  output data_t      pa_data,
  output logic       pb_wr,
  output bank_t      pb_bank,
  output row_t       pb_row,
  output data_t      pb_data,
  output logic       map_wr,
  output row_t       map_row,
  output map_entry_t map_data,
  output logic       cache_wr,
  output row_t       cache_row,
  output data_t      cache_data
);

  logic   deq_two;
  logic   e2_vld;
  addr_t  e2_addr;
  data_t  e2_data;
  logic   e2_conflict;
  logic   evict;
  logic   clear_map;
  route_t e1_route;
  route_t e2_route;

  // Two drains only when no read holds a bank and the rows differ
  assign deq_two = !rd_en && count >= qcount_t'(2) && head0_addr.row != head1_addr.row;
  assign deq_cnt = deq_two ? 2'd2 : (count != '0) ? 2'd1 : 2'd0;

  // E2 is the last entry drained, E1 exists only on a double drain
  assign e2_vld  = deq_two ? head1_vld : head0_vld;
  assign e2_addr = deq_two ? head1_addr : head0_addr;
  assign e2_data = deq_two ? head1_data : head0_data;

  // Cache already holds E1's bank at that row
  assign e1_route = !deq_two ? ROUTE_IDLE :
                    (map0.vld && map0.bank == head0_addr.bank) ? ROUTE_CACHE : ROUTE_PIVOT;

  assign e2_conflict = (e1_route == ROUTE_PIVOT && head0_addr.bank == e2_addr.bank) ||
                       (rd_en && rd_addr.bank == e2_addr.bank);
  assign e2_route    = !e2_vld ? ROUTE_IDLE : e2_conflict ? ROUTE_CACHE : ROUTE_PIVOT;

  // Cache row owned by another bank goes home first
  assign evict     = e2_route == ROUTE_CACHE && map1.vld && map1.bank != e2_addr.bank;
  // Stale cache copy of E2's bank
  assign clear_map = e2_route == ROUTE_PIVOT && map1.vld && map1.bank == e2_addr.bank;

  assign pa_wr   = e1_route == ROUTE_PIVOT;
  assign pa_bank = head0_addr.bank;
  assign pa_row  = head0_addr.row;
  assign pa_data = head0_data;

  assign pb_wr   = e2_route == ROUTE_PIVOT || evict;
  assign pb_bank = evict ? map1.bank : e2_addr.bank;
  assign pb_row  = e2_addr.row;
  assign pb_data = evict ? cache1_data : e2_data;

  assign map_wr   = e2_route == ROUTE_CACHE || clear_map;
  assign map_row  = e2_addr.row;
  assign map_data = clear_map ? '0 : map_entry_t'{vld: 1'b1, bank: e2_addr.bank};

  assign cache_wr   = e1_route == ROUTE_CACHE || e2_route == ROUTE_CACHE;
  assign cache_row  = (e1_route == ROUTE_CACHE) ? head0_addr.row : e2_addr.row;
  assign cache_data = (e1_route == ROUTE_CACHE) ? head0_data : e2_data;

  // A cached E1 leaves E2 without a bank conflict
  always_comb begin
    if (e1_route == ROUTE_CACHE) begin
      assert final (e2_route != ROUTE_CACHE);
    end
  end

endmodule

//--- hw/mpmem_addr_pkg.sv
`include "mpmem_cfg.svh"

package mpmem_addr_pkg;

  typedef logic [`MP_BANK_BITS-1:0] bank_t;
  typedef logic [`MP_ROW_BITS-1:0] row_t;

  // Bank sits in the upper address bits
  typedef struct packed {
    bank_t bank;
    row_t  row;
  } addr_t;

  typedef logic [`MP_DATA_WIDTH-1:0] data_t;

endpackage

//--- hw/mpmem_route_pkg.sv
`include "mpmem_cfg.svh"

package mpmem_route_pkg;

  import mpmem_addr_pkg::*;

  // Names the bank whose data the cache row currently holds
  typedef struct packed {
    logic  vld;
    bank_t bank;
  } map_entry_t;

  typedef enum logic [1:0] {
    ROUTE_IDLE,
    ROUTE_PIVOT,
    ROUTE_CACHE
  } route_t;

  typedef logic [`MP_QUEUE_BITS-1:0] qcount_t;

endpackage

//--- hw/mpmem_top.sv
`include "mpmem_cfg.svh"

module mpmem_top import mpmem_addr_pkg::*; (
  input  logic       clk,
  input  logic       rstvld,
  input  logic [1:0] wr_en,
  input  addr_t      wr_addr0,
  input  addr_t      wr_addr1,
  input  data_t      wr_data0,
  input  data_t      wr_data1,
  input  logic       rd_en,
  input  addr_t      rd_addr,
  output logic       rd_vld,
  output data_t      rd_data,
  output logic       ready
);

  logic [1:0]                wr_en_g;
  logic                      rd_en_g;
  logic [`MP_QUEUE_BITS-1:0] count;
  logic [1:0]                deq_cnt;
  logic                      head0_vld, head1_vld;
  addr_t                     head0_addr, head1_addr;
  data_t                     head0_data, head1_data;
  logic                      rd_hit;
  data_t                     rd_hit_data;
  logic [`MP_BANK_BITS:0]    map0, map1, map_data, rd_map;
  logic                      map_wr, cache_wr, init_busy;
  row_t                      lookup_row1, map_row, cache_row;
  data_t                     cache1_data, cache_data, rd_cache, pivot_data;
  logic                      pa_wr, pb_wr;
  bank_t                     pa_bank, pb_bank;
  row_t                      pa_row, pb_row;
  data_t                     pa_data, pb_data;

  // Requests count only while ready is up
  assign wr_en_g = wr_en & {2{ready}};
  assign rd_en_g = rd_en & ready;

  // Second lookup follows the entry drained last
  assign lookup_row1 = (deq_cnt == 2'd2) ? head1_addr.row : head0_addr.row;

  write_queue i_write_queue (
    .push_en(wr_en_g), .push_addr0(wr_addr0), .push_addr1(wr_addr1),
    .push_data0(wr_data0), .push_data1(wr_data1), .*
  );

  drain_ctrl i_drain_ctrl (.rd_en(rd_en_g), .*);

  row_store i_row_store (
    .rd_row(rd_addr.row), .row0(head0_addr.row), .row1(lookup_row1), .*
  );

  pivot_banks i_pivot_banks (
    .rd_bank(rd_addr.bank), .rd_row(rd_addr.row), .rd_data(pivot_data), .*
  );

  read_path i_read_path (.rd_en(rd_en_g), .*);

endmodule

//--- hw/pivot_banks.sv
`include "mpmem_cfg.svh"

module pivot_banks import mpmem_addr_pkg::*; (
  input  logic  clk,
  input  bank_t rd_bank,
  input  row_t  rd_row,
  input  logic  pa_wr,
  input  bank_t pa_bank,
  input  row_t  pa_row,
  input  data_t pa_data,
  input  logic  pb_wr,
  input  bank_t pb_bank,
  input  row_t  pb_row,
  input  data_t pb_data,
  output data_t rd_data
);

  data_t mem [`MP_NUM_BANKS][`MP_NUM_ROWS];

  always_ff @(posedge clk) begin
    if (pa_wr) begin
      mem[pa_bank][pa_row] <= pa_data;
    end
    if (pb_wr) begin
      mem[pb_bank][pb_row] <= pb_data;
    end
  end

  assign rd_data = mem[rd_bank][rd_row];

  // Drained entries never share a row, so neither can evictions
  assert property (@(posedge clk)
    pa_wr && pb_wr |-> (pa_bank != pb_bank || pa_row != pb_row));

endmodule

//--- hw/read_path.sv
`include "mpmem_cfg.svh"

module read_path import mpmem_addr_pkg::*, mpmem_route_pkg::*; (
  input  logic       clk,
  input  logic       rstvld,
  input  logic       rd_en,
  input  addr_t      rd_addr,
  input  logic       rd_hit,
  input  data_t      rd_hit_data,
  input  map_entry_t rd_map,
  input  data_t      rd_cache,
  input  data_t      pivot_data,
  input  logic       init_busy,
  input  qcount_t    count,
  output logic       rd_vld,
  output data_t      rd_data,
  output logic       ready
);

  data_t rd_sel;

  // Queue first, then the cache if it holds this bank's row
  assign rd_sel = rd_hit ? rd_hit_data :
                  (rd_map.vld && rd_map.bank == rd_addr.bank) ? rd_cache : pivot_data;

  // One below the limit since the count is a cycle old when ready is seen
  always_ff @(posedge clk) begin
    if (rstvld) begin
      rd_vld <= 1'b0;
      ready  <= 1'b0;
    end else begin
      rd_vld <= rd_en;
      ready  <= !init_busy && count < qcount_t'(`MP_QUEUE_DEPTH - 2);
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= rd_sel;
    end
  end

  assert property (@(posedge clk) disable iff (rstvld)
    ready |-> count <= qcount_t'(`MP_QUEUE_DEPTH - 2));

endmodule

//--- hw/row_store.sv
`include "mpmem_cfg.svh"

module row_store import mpmem_addr_pkg::*, mpmem_route_pkg::*; (
  input  logic       clk,
  input  logic       rstvld,
  input  row_t       rd_row,
  input  row_t       row0,
  input  row_t       row1,
  input  logic       map_wr,
  input  row_t       map_row,
  input  map_entry_t map_data,
  input  logic       cache_wr,
  input  row_t       cache_row,
  input  data_t      cache_data,
  output map_entry_t rd_map,
  output data_t      rd_cache,
  output map_entry_t map0,
  output map_entry_t map1,
  output data_t      cache1_data,
  output logic       init_busy
);

  map_entry_t             map_mem [`MP_NUM_ROWS];
  data_t                  cache_mem [`MP_NUM_ROWS];
  logic [`MP_ROW_BITS:0]  sweep_cnt;
  row_t                   sweep_row;

  assign init_busy = sweep_cnt < (`MP_ROW_BITS+1)'(`MP_NUM_ROWS);
  assign sweep_row = sweep_cnt[`MP_ROW_BITS-1:0];

  always_ff @(posedge clk) begin
    if (rstvld) begin
      sweep_cnt <= '0;
    end else if (init_busy) begin
      sweep_cnt <= sweep_cnt + 1'b1;
    end
  end

  // Sweep owns both write ports until every row is clear
  always_ff @(posedge clk) begin
    if (init_busy) begin
      map_mem[sweep_row]   <= '0;
      cache_mem[sweep_row] <= '0;
    end else begin
      if (map_wr) begin
        map_mem[map_row] <= map_data;
      end
      if (cache_wr) begin
        cache_mem[cache_row] <= cache_data;
      end
    end
  end

  assign rd_map      = map_mem[rd_row];
  assign rd_cache    = cache_mem[rd_row];
  assign map0        = map_mem[row0];
  assign map1        = map_mem[row1];
  assign cache1_data = cache_mem[row1];

  // Queue stays empty while the host waits for ready
  assert property (@(posedge clk) disable iff (rstvld)
    init_busy |-> !map_wr && !cache_wr);

endmodule

//--- hw/write_queue.sv
`include "mpmem_cfg.svh"

module write_queue import mpmem_addr_pkg::*, mpmem_route_pkg::*; (
  input  logic       clk,
  input  logic       rstvld,
  input  logic [1:0] push_en,
  input  addr_t      push_addr0,
  input  addr_t      push_addr1,
  input  data_t      push_data0,
  input  data_t      push_data1,
  input  logic [1:0] deq_cnt,
  input  addr_t      rd_addr,
  output qcount_t    count,
  output logic       head0_vld,
  output addr_t      head0_addr,
  output data_t      head0_data,
  output logic       head1_vld,
  output addr_t      head1_addr,
  output data_t      head1_data,
  output logic       rd_hit,
  output data_t      rd_hit_data
);

  addr_t   q_addr [`MP_QUEUE_DEPTH];
  data_t   q_data [`MP_QUEUE_DEPTH];
  logic    push0;
  logic    push1;
  qcount_t base;

  // Port 1 wins when both ports hit one address
  assign push0 = push_en[0] && !(push_en[1] && push_addr0 == push_addr1);
  assign push1 = push_en[1];
  assign base  = count - qcount_t'(deq_cnt);

  always_ff @(posedge clk) begin
    if (rstvld) begin
      count <= '0;
    end else begin
      count <= base + qcount_t'(push0) + qcount_t'(push1);
    end
  end

  // Survivors slide toward the head, new entries land right behind them
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MP_QUEUE_DEPTH; i++) begin
      if (push0 && i == int'(base)) begin
        q_addr[i] <= push_addr0;
        q_data[i] <= push_data0;
      end else if (push1 && i == int'(base) + int'(push0)) begin
        q_addr[i] <= push_addr1;
        q_data[i] <= push_data1;
      end else if (i + int'(deq_cnt) < `MP_QUEUE_DEPTH) begin
        q_addr[i] <= q_addr[i + int'(deq_cnt)];
        q_data[i] <= q_data[i + int'(deq_cnt)];
      end
    end
  end

  assign head0_vld  = count != '0;
  assign head0_addr = q_addr[0];
  assign head0_data = q_data[0];
  assign head1_vld  = count > qcount_t'(1);
  assign head1_addr = q_addr[1];
  assign head1_data = q_data[1];

  // Oldest to newest so the last match sticks
  always_comb begin
    rd_hit      = 1'b0;
    rd_hit_data = '0;
    for (int i = 0; i < `MP_QUEUE_DEPTH; i++) begin
      if (i < int'(count) && q_addr[i] == rd_addr) begin
        rd_hit      = 1'b1;
        rd_hit_data = q_data[i];
      end
    end
  end

  // Host back-pressure has to keep occupancy within the queue
  assert property (@(posedge clk) disable iff (rstvld)
    count <= qcount_t'(`MP_QUEUE_DEPTH));

endmodule

//--- include/mpmem_cfg.svh
`ifndef MPMEM_CFG_SVH
`define MPMEM_CFG_SVH

// Pivot bank geometry
`define MP_NUM_BANKS   4
`define MP_BANK_BITS   2
`define MP_NUM_ROWS    16
`define MP_ROW_BITS    4

`define MP_DATA_WIDTH  16

// Pending write queue
`define MP_QUEUE_DEPTH 8
`define MP_QUEUE_BITS  4

`endif
